// ==== design/cpu_pkg.sv ====
package cpu_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths and sizes
    ////////////////////////////////////////////////////////////////////////////

    localparam int WORD_W      = 32;
    localparam int PC_W        = 6;
    localparam int REG_ADDR_W  = 6;
    localparam int DMEM_ADDR_W = 7;
    localparam int IMM_W       = 15;
    localparam int OP_W        = 4;

    localparam int IMEM_DEPTH  = 64;
    localparam int REG_COUNT   = 64;
    localparam int DMEM_DEPTH  = 128;

    typedef logic [WORD_W-1:0]      word_t;
    typedef logic [WORD_W-1:0]      instr_t;
    typedef logic [PC_W-1:0]        pc_t;
    typedef logic [REG_ADDR_W-1:0]  reg_addr_t;
    typedef logic [DMEM_ADDR_W-1:0] dmem_addr_t;
    typedef logic [IMM_W-1:0]       imm_t;

    // Bit 3 set selects the logic group, clear the arithmetic group
    typedef enum logic [OP_W-1:0] {
        OP_ADD   = 4'b0000,
        OP_SUB   = 4'b0011,
        OP_LOAD  = 4'b0100,
        OP_STORE = 4'b0110,
        OP_AND   = 4'b1000,
        OP_OR    = 4'b1001,
        OP_XOR   = 4'b1010,
        OP_NOT   = 4'b1011,
        OP_SLL   = 4'b1101,
        OP_NOP   = 4'b1111
    } opcode_t;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction fields
    ////////////////////////////////////////////////////////////////////////////

    localparam int USE_IMM_BIT = 31;
    localparam int RS_MSB      = 30;
    localparam int RS_LSB      = 25;
    localparam int RD_MSB      = 24;
    localparam int RD_LSB      = 19;
    localparam int OP_MSB      = 18;
    localparam int OP_LSB      = 15;
    localparam int RT_MSB      = 14;   // rt overlaps the top of the immediate
    localparam int RT_LSB      = 9;
    localparam int IMM_MSB     = 14;

    // Opcode NOP, every other field zero
    localparam instr_t NOP_INSTR = {13'b0, OP_NOP, 15'b0};

endpackage

// ==== design/instr_fetch.sv ====
`timescale 1ns/1ps

module instr_fetch (
    input  logic            clk,
    input  logic            reset,
    input  logic            imem_we,
    input  cpu_pkg::pc_t    imem_addr,
    input  cpu_pkg::instr_t imem_wdata,
    output cpu_pkg::pc_t    pc,
    output cpu_pkg::instr_t instr
);

    cpu_pkg::instr_t imem [cpu_pkg::IMEM_DEPTH];

    ////////////////////////////////////////////////////////////////////////////
    // Program load port
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Program counter and registered read
    ////////////////////////////////////////////////////////////////////////////

    // No branches, so the counter just runs and wraps at 63
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc    <= '0;
            instr <= cpu_pkg::NOP_INSTR;
        end else begin
            pc    <= pc + 1'b1;
            instr <= imem[pc];   // Word at the old pc
        end
    end

endmodule

// ==== design/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder (
    input  cpu_pkg::instr_t    instr,
    output cpu_pkg::reg_addr_t rs,
    output cpu_pkg::reg_addr_t rt,
    output cpu_pkg::reg_addr_t rd,
    output cpu_pkg::opcode_t   op,
    output logic               use_imm,
    output cpu_pkg::word_t     imm_ext,
    output logic               reg_we,
    output logic               mem_we,
    output logic               wb_from_mem
);

    logic [cpu_pkg::OP_W-1:0] op_raw;
    cpu_pkg::imm_t            imm;

    assign use_imm = instr[cpu_pkg::USE_IMM_BIT];
    assign rs      = instr[cpu_pkg::RS_MSB:cpu_pkg::RS_LSB];
    assign rd      = instr[cpu_pkg::RD_MSB:cpu_pkg::RD_LSB];
    assign rt      = instr[cpu_pkg::RT_MSB:cpu_pkg::RT_LSB];
    assign op_raw  = instr[cpu_pkg::OP_MSB:cpu_pkg::OP_LSB];
    assign imm     = instr[cpu_pkg::IMM_MSB:0];

    assign imm_ext = {{(cpu_pkg::WORD_W - cpu_pkg::IMM_W){imm[cpu_pkg::IMM_W-1]}}, imm};

    // Unlisted codes fold into NOP
    always_comb begin
        case (op_raw)
            cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_LOAD, cpu_pkg::OP_STORE,
            cpu_pkg::OP_AND, cpu_pkg::OP_OR, cpu_pkg::OP_XOR, cpu_pkg::OP_NOT,
            cpu_pkg::OP_SLL: op = cpu_pkg::opcode_t'(op_raw);
            default:         op = cpu_pkg::OP_NOP;
        endcase
    end

    always_comb begin
        reg_we      = 1'b0;
        mem_we      = 1'b0;
        wb_from_mem = 1'b0;
        case (op)
            cpu_pkg::OP_LOAD: begin
                reg_we      = 1'b1;
                wb_from_mem = 1'b1;
            end
            cpu_pkg::OP_STORE: mem_we = 1'b1;
            cpu_pkg::OP_NOP:   ;   // No side effects
            default:           reg_we = 1'b1;
        endcase
    end

endmodule

// ==== design/register_file.sv ====
`timescale 1ns/1ps

module register_file (
    input  logic               clk,
    input  logic               reset,
    input  cpu_pkg::reg_addr_t rs,
    input  cpu_pkg::reg_addr_t rt,
    input  cpu_pkg::reg_addr_t rd,
    input  logic               reg_we,
    input  cpu_pkg::word_t     wb_data,
    output cpu_pkg::word_t     operand_a,
    output cpu_pkg::word_t     rt_data
);

    cpu_pkg::word_t regs [cpu_pkg::REG_COUNT];

    // Reads see the old value during a write cycle
    assign operand_a = regs[rs];
    assign rt_data   = regs[rt];

    // Register 0 is writable like any other
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < cpu_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_we) begin
            regs[rd] <= wb_data;
        end
    end

endmodule

// ==== design/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::opcode_t op,
    input  cpu_pkg::word_t   operand_a,
    input  cpu_pkg::word_t   rt_data,
    input  cpu_pkg::word_t   imm_ext,
    input  logic             use_imm,
    output cpu_pkg::word_t   operand_b,
    output cpu_pkg::word_t   alu_result
);

    ////////////////////////////////////////////////////////////////////////////
    // Operand B select
    ////////////////////////////////////////////////////////////////////////////

    assign operand_b = use_imm ? imm_ext : rt_data;

    ////////////////////////////////////////////////////////////////////////////
    // Result
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (op)
            // Arithmetic group
            cpu_pkg::OP_ADD: alu_result = operand_a + operand_b;
            cpu_pkg::OP_SUB: alu_result = operand_a - operand_b;

            // Logic group
            cpu_pkg::OP_AND: alu_result = operand_a & operand_b;
            cpu_pkg::OP_OR:  alu_result = operand_a | operand_b;
            cpu_pkg::OP_XOR: alu_result = operand_a ^ operand_b;
            cpu_pkg::OP_NOT: alu_result = ~operand_a;
            cpu_pkg::OP_SLL: alu_result = {operand_a[cpu_pkg::WORD_W-2:0], 1'b0};

            // LOAD and STORE use A as the address
            cpu_pkg::OP_LOAD,
            cpu_pkg::OP_STORE,
            cpu_pkg::OP_NOP: alu_result = operand_a;

            default:         alu_result = operand_a;
        endcase
    end

endmodule

// ==== design/mem_writeback.sv ====
`timescale 1ns/1ps

module mem_writeback (
    input  logic           clk,
    input  cpu_pkg::word_t alu_result,
    input  cpu_pkg::word_t rt_data,
    input  logic           mem_we,
    input  logic           wb_from_mem,
    output cpu_pkg::word_t mem_rdata,
    output cpu_pkg::word_t wb_data
);

    cpu_pkg::word_t     dmem [cpu_pkg::DMEM_DEPTH];
    cpu_pkg::dmem_addr_t dmem_addr;

    assign dmem_addr = alu_result[cpu_pkg::DMEM_ADDR_W-1:0];   // Upper bits ignored

    assign mem_rdata = dmem[dmem_addr];

    always_ff @(posedge clk) begin
        if (mem_we) begin
            dmem[dmem_addr] <= rt_data;
        end
    end

    // Write-back source
    assign wb_data = wb_from_mem ? mem_rdata : alu_result;

endmodule

// ==== design/mini_cpu.sv ====
`timescale 1ns/1ps

module mini_cpu (
    input  logic            clk,
    input  logic            reset,

    // Program load
    input  logic            imem_we,
    input  cpu_pkg::pc_t    imem_addr,
    input  cpu_pkg::instr_t imem_wdata,

    // Debug view
    output cpu_pkg::pc_t    pc,
    output cpu_pkg::instr_t instr,
    output cpu_pkg::word_t  operand_a,
    output cpu_pkg::word_t  operand_b,
    output cpu_pkg::word_t  alu_result,
    output cpu_pkg::word_t  mem_rdata,
    output cpu_pkg::word_t  wb_data
);

    cpu_pkg::reg_addr_t rs;
    cpu_pkg::reg_addr_t rt;
    cpu_pkg::reg_addr_t rd;
    cpu_pkg::opcode_t   op;
    logic               use_imm;
    cpu_pkg::word_t     imm_ext;
    logic               reg_we;
    logic               mem_we;
    logic               wb_from_mem;
    cpu_pkg::word_t     rt_data;

    ////////////////////////////////////////////////////////////////////////////
    // Fetch and decode
    ////////////////////////////////////////////////////////////////////////////

    instr_fetch instr_fetch_inst (
        .clk        (clk),
        .reset      (reset),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .pc         (pc),
        .instr      (instr)
    );

    instr_decoder instr_decoder_inst (
        .instr       (instr),
        .rs          (rs),
        .rt          (rt),
        .rd          (rd),
        .op          (op),
        .use_imm     (use_imm),
        .imm_ext     (imm_ext),
        .reg_we      (reg_we),
        .mem_we      (mem_we),
        .wb_from_mem (wb_from_mem)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Execute
    ////////////////////////////////////////////////////////////////////////////

    register_file register_file_inst (
        .clk       (clk),
        .reset     (reset),
        .rs        (rs),
        .rt        (rt),
        .rd        (rd),
        .reg_we    (reg_we),
        .wb_data   (wb_data),
        .operand_a (operand_a),
        .rt_data   (rt_data)
    );

    alu alu_inst (
        .op         (op),
        .operand_a  (operand_a),
        .rt_data    (rt_data),
        .imm_ext    (imm_ext),
        .use_imm    (use_imm),
        .operand_b  (operand_b),
        .alu_result (alu_result)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Memory and write-back
    ////////////////////////////////////////////////////////////////////////////

    mem_writeback mem_writeback_inst (
        .clk         (clk),
        .alu_result  (alu_result),
        .rt_data     (rt_data),   // Store data comes from rt, never the immediate
        .mem_we      (mem_we),
        .wb_from_mem (wb_from_mem),
        .mem_rdata   (mem_rdata),
        .wb_data     (wb_data)
    );

endmodule

// ==== sim/cpu_model.svh ====
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// Expected machine state
////////////////////////////////////////////////////////////////////////////

cpu_pkg::word_t exp_regs  [cpu_pkg::REG_COUNT];
cpu_pkg::word_t exp_mem   [cpu_pkg::DMEM_DEPTH];
bit             mem_known [cpu_pkg::DMEM_DEPTH];   // Set once a store lands there

// Reset clears registers only, data memory keeps its contents
function automatic void clear_expected_regs();
    for (int i = 0; i < cpu_pkg::REG_COUNT; i++) begin
        exp_regs[i] = '0;
    end
endfunction

// Immediate read as a two's complement 15-bit number
function automatic cpu_pkg::word_t sign_extend(input cpu_pkg::imm_t imm);
    int value;
    value = int'(imm);
    if (imm[cpu_pkg::IMM_W-1]) begin
        value = value - (1 << cpu_pkg::IMM_W);
    end
    return cpu_pkg::word_t'(value);
endfunction

////////////////////////////////////////////////////////////////////////////
// Opcode table
////////////////////////////////////////////////////////////////////////////

function automatic cpu_pkg::word_t expected_result(input logic [cpu_pkg::OP_W-1:0] code,
                                                   input cpu_pkg::word_t a,
                                                   input cpu_pkg::word_t b);
    case (code)
        cpu_pkg::OP_ADD: return a + b;
        cpu_pkg::OP_SUB: return a - b;
        cpu_pkg::OP_AND: return a & b;
        cpu_pkg::OP_OR:  return a | b;
        cpu_pkg::OP_XOR: return a ^ b;
        cpu_pkg::OP_NOT: return ~a;
        cpu_pkg::OP_SLL: return a << 1;
        default:         return a;   // A passes through, also as memory address
    endcase
endfunction

function automatic bit writes_register(input logic [cpu_pkg::OP_W-1:0] code);
    case (code)
        cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_LOAD, cpu_pkg::OP_AND,
        cpu_pkg::OP_OR, cpu_pkg::OP_XOR, cpu_pkg::OP_NOT, cpu_pkg::OP_SLL: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

`endif

// ==== sim/tb_mini_cpu.sv ====
`timescale 1ns/1ps

module tb_mini_cpu;

    localparam int TEST_COUNT  = 5;
    localparam int TEST_CYCLES = 150;                            // Reset, load and run
    localparam int MAX_CYCLES  = TEST_COUNT * TEST_CYCLES + 250;

    logic            clk;
    logic            reset;
    logic            imem_we;
    cpu_pkg::pc_t    imem_addr;
    cpu_pkg::instr_t imem_wdata;
    cpu_pkg::pc_t    pc;
    cpu_pkg::instr_t instr;
    cpu_pkg::word_t  operand_a;
    cpu_pkg::word_t  operand_b;
    cpu_pkg::word_t  alu_result;
    cpu_pkg::word_t  mem_rdata;
    cpu_pkg::word_t  wb_data;

    cpu_pkg::instr_t prog [cpu_pkg::IMEM_DEPTH];
    string           cur_test;
    int              test_errors;
    int              pass_count;
    int              fail_count;
    int              cycle_count;
    int              seed = 41440;

    `include "cpu_model.svh"

    mini_cpu mini_cpu_inst (
        .clk        (clk),
        .reset      (reset),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .pc         (pc),
        .instr      (instr),
        .operand_a  (operand_a),
        .operand_b  (operand_b),
        .alu_result (alu_result),
        .mem_rdata  (mem_rdata),
        .wb_data    (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_word(input cpu_pkg::word_t expected, input cpu_pkg::word_t actual,
                              input string what);
        if (actual !== expected) begin
            $display("** Error: %s: %s expected %h actual %h", cur_test, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_pc(input cpu_pkg::pc_t expected, input cpu_pkg::pc_t actual,
                            input string what);
        if (actual !== expected) begin
            $display("** Error: %s: %s expected %0d actual %0d", cur_test, what, expected, actual);
            test_errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Instruction assembly and stimulus
    ////////////////////////////////////////////////////////////////////////////

    function automatic cpu_pkg::instr_t imm_instr(input logic [cpu_pkg::OP_W-1:0] code,
                                                  input cpu_pkg::reg_addr_t rd,
                                                  input cpu_pkg::reg_addr_t rs,
                                                  input cpu_pkg::imm_t imm);
        cpu_pkg::instr_t w;
        w = '0;
        w[cpu_pkg::USE_IMM_BIT]             = 1'b1;
        w[cpu_pkg::RS_MSB:cpu_pkg::RS_LSB]  = rs;
        w[cpu_pkg::RD_MSB:cpu_pkg::RD_LSB]  = rd;
        w[cpu_pkg::OP_MSB:cpu_pkg::OP_LSB]  = code;
        w[cpu_pkg::IMM_MSB:0]               = imm;
        return w;
    endfunction

    function automatic cpu_pkg::instr_t reg_instr(input logic [cpu_pkg::OP_W-1:0] code,
                                                  input cpu_pkg::reg_addr_t rd,
                                                  input cpu_pkg::reg_addr_t rs,
                                                  input cpu_pkg::reg_addr_t rt);
        cpu_pkg::instr_t w;
        w = '0;
        w[cpu_pkg::RS_MSB:cpu_pkg::RS_LSB] = rs;
        w[cpu_pkg::RD_MSB:cpu_pkg::RD_LSB] = rd;
        w[cpu_pkg::OP_MSB:cpu_pkg::OP_LSB] = code;
        w[cpu_pkg::RT_MSB:cpu_pkg::RT_LSB] = rt;
        return w;
    endfunction

    function automatic cpu_pkg::imm_t random_imm();
        logic [31:0] r;
        r = $random(seed);
        return r[cpu_pkg::IMM_W-1:0];
    endfunction

    function automatic cpu_pkg::imm_t negative_imm();
        return random_imm() | 15'h4000;
    endfunction

    // One executed word against the model, then the model commits it
    task automatic check_cycle(input int k);
        cpu_pkg::instr_t          word;
        logic [cpu_pkg::OP_W-1:0] code;
        cpu_pkg::reg_addr_t       rs;
        cpu_pkg::reg_addr_t       rt;
        cpu_pkg::reg_addr_t       rd;
        cpu_pkg::word_t           a;
        cpu_pkg::word_t           b;
        cpu_pkg::word_t           res;
        cpu_pkg::word_t           wb;
        cpu_pkg::dmem_addr_t      addr;
        bit                       wb_known;
        word = prog[(k - 1) % cpu_pkg::IMEM_DEPTH];
        code = word[cpu_pkg::OP_MSB:cpu_pkg::OP_LSB];
        rs   = word[cpu_pkg::RS_MSB:cpu_pkg::RS_LSB];
        rt   = word[cpu_pkg::RT_MSB:cpu_pkg::RT_LSB];
        rd   = word[cpu_pkg::RD_MSB:cpu_pkg::RD_LSB];
        a    = exp_regs[rs];
        b    = word[cpu_pkg::USE_IMM_BIT] ? sign_extend(word[cpu_pkg::IMM_MSB:0]) : exp_regs[rt];
        res  = expected_result(code, a, b);
        addr = a[cpu_pkg::DMEM_ADDR_W-1:0];
        wb_known = 1'b1;
        wb       = res;
        if (code == cpu_pkg::OP_LOAD) begin
            wb_known = mem_known[addr];
            wb       = exp_mem[addr];
        end
        check_pc(cpu_pkg::pc_t'(k % cpu_pkg::IMEM_DEPTH), pc, $sformatf("pc cycle %0d", k));
        check_word(word, instr, $sformatf("instr cycle %0d", k));
        check_word(a, operand_a, $sformatf("operand_a cycle %0d", k));
        check_word(b, operand_b, $sformatf("operand_b cycle %0d", k));
        check_word(res, alu_result, $sformatf("alu_result cycle %0d", k));
        if (mem_known[addr]) begin
            check_word(exp_mem[addr], mem_rdata, $sformatf("mem_rdata cycle %0d", k));
        end
        if (wb_known) begin
            check_word(wb, wb_data, $sformatf("wb_data cycle %0d", k));
        end
        if (writes_register(code)) begin
            exp_regs[rd] = wb;
        end
        if (code == cpu_pkg::OP_STORE) begin
            exp_mem[addr]   = exp_regs[rt];   // Store data is rt even in immediate form
            mem_known[addr] = 1'b1;
        end
    endtask

    task automatic run_program(input int n_cycles);
        @(posedge clk);
        reset <= 1'b1;
        clear_expected_regs();
        for (int i = 0; i < cpu_pkg::IMEM_DEPTH; i++) begin
            @(posedge clk);
            imem_we    <= 1'b1;
            imem_addr  <= cpu_pkg::pc_t'(i);
            imem_wdata <= prog[i];
        end
        @(posedge clk);   // Last word lands here
        imem_we <= 1'b0;
        reset   <= 1'b0;
        @(negedge clk);
        check_pc('0, pc, "pc after reset");
        check_word(cpu_pkg::NOP_INSTR, instr, "instr after reset");
        for (int k = 1; k <= n_cycles; k++) begin
            @(posedge clk);
            @(negedge clk);
            check_cycle(k);
        end
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = 0;
        for (int i = 0; i < cpu_pkg::IMEM_DEPTH; i++) begin
            prog[i] = cpu_pkg::NOP_INSTR;
        end
    endtask

    task automatic report_test();
        if (test_errors == 0) begin
            $display("%s: PASS", cur_test);
            pass_count++;
        end else begin
            $display("%s: FAIL with %0d errors", cur_test, test_errors);
            fail_count++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic reset_and_fetch();
        start_test("reset_and_fetch");
        for (int i = 0; i < cpu_pkg::IMEM_DEPTH; i++) begin
            prog[i] = imm_instr(cpu_pkg::OP_ADD, cpu_pkg::reg_addr_t'(i), 6'd0,
                                cpu_pkg::imm_t'(i * 7 + 1));
        end
        run_program(cpu_pkg::IMEM_DEPTH + 2);   // Through the wrap to 0
        report_test();
    endtask

    task automatic imm_and_reg_arith();
        start_test("imm_and_reg_arith");
        prog[0] = imm_instr(cpu_pkg::OP_ADD, 6'd1, 6'd0, 15'd5);
        prog[1] = imm_instr(cpu_pkg::OP_ADD, 6'd2, 6'd0, negative_imm());
        prog[2] = imm_instr(cpu_pkg::OP_ADD, 6'd3, 6'd1, random_imm());
        prog[3] = reg_instr(cpu_pkg::OP_XOR, 6'd4, 6'd1, 6'd2);
        prog[4] = reg_instr(cpu_pkg::OP_SLL, 6'd5, 6'd4, 6'd0);
        prog[5] = reg_instr(cpu_pkg::OP_OR, 6'd6, 6'd3, 6'd5);
        prog[6] = reg_instr(cpu_pkg::OP_SUB, 6'd7, 6'd6, 6'd2);
        prog[7] = imm_instr(cpu_pkg::OP_SUB, 6'd8, 6'd7, negative_imm());
        prog[8] = reg_instr(cpu_pkg::OP_ADD, 6'd9, 6'd8, 6'd7);
        run_program(12);
        report_test();
    endtask

    task automatic logic_and_shift();
        start_test("logic_and_shift");
        prog[0]  = imm_instr(cpu_pkg::OP_ADD, 6'd1, 6'd0, random_imm());
        prog[1]  = imm_instr(cpu_pkg::OP_ADD, 6'd2, 6'd0, negative_imm());
        prog[2]  = imm_instr(cpu_pkg::OP_ADD, 6'd3, 6'd0, random_imm());
        prog[3]  = reg_instr(cpu_pkg::OP_AND, 6'd4, 6'd1, 6'd2);
        prog[4]  = imm_instr(cpu_pkg::OP_OR, 6'd5, 6'd2, random_imm());
        prog[5]  = imm_instr(cpu_pkg::OP_XOR, 6'd6, 6'd3, negative_imm());
        prog[6]  = reg_instr(cpu_pkg::OP_NOT, 6'd7, 6'd4, 6'd0);
        prog[7]  = reg_instr(cpu_pkg::OP_SLL, 6'd8, 6'd7, 6'd0);
        prog[8]  = reg_instr(cpu_pkg::OP_SLL, 6'd8, 6'd8, 6'd0);
        prog[9]  = imm_instr(cpu_pkg::OP_AND, 6'd9, 6'd6, negative_imm());
        prog[10] = reg_instr(cpu_pkg::OP_XOR, 6'd10, 6'd5, 6'd9);
        prog[11] = imm_instr(cpu_pkg::OP_ADD, 6'd11, 6'd10, 15'd0);   // Read back via operand_a
        run_program(14);
        report_test();
    endtask

    task automatic store_then_load();
        cpu_pkg::imm_t addr_imm;
        cpu_pkg::imm_t alias_imm;
        start_test("store_then_load");
        addr_imm  = random_imm() & 15'h007f;
        alias_imm = 15'h0280 | {8'h00, addr_imm[6:0] ^ 7'h40};   // Upper bits set
        prog[0]  = imm_instr(cpu_pkg::OP_ADD, 6'd1, 6'd0, addr_imm);
        prog[1]  = imm_instr(cpu_pkg::OP_ADD, 6'd2, 6'd0, negative_imm());
        prog[2]  = reg_instr(cpu_pkg::OP_STORE, 6'd0, 6'd1, 6'd2);
        prog[3]  = reg_instr(cpu_pkg::OP_LOAD, 6'd3, 6'd1, 6'd0);
        prog[4]  = imm_instr(cpu_pkg::OP_ADD, 6'd4, 6'd3, 15'd0);
        prog[5]  = imm_instr(cpu_pkg::OP_ADD, 6'd5, 6'd0, alias_imm);
        prog[6]  = imm_instr(cpu_pkg::OP_ADD, 6'd6, 6'd0, random_imm());
        prog[7]  = reg_instr(cpu_pkg::OP_STORE, 6'd0, 6'd5, 6'd6);
        prog[8]  = reg_instr(cpu_pkg::OP_LOAD, 6'd7, 6'd1, 6'd0);
        prog[9]  = imm_instr(cpu_pkg::OP_ADD, 6'd8, 6'd0, alias_imm & 15'h007f);
        prog[10] = reg_instr(cpu_pkg::OP_LOAD, 6'd9, 6'd8, 6'd0);
        prog[11] = imm_instr(cpu_pkg::OP_ADD, 6'd10, 6'd9, 15'd0);
        run_program(14);
        report_test();
    endtask

    task automatic non_writing_codes();
        start_test("non_writing_codes");
        prog[0]  = imm_instr(cpu_pkg::OP_ADD, 6'd1, 6'd0, negative_imm());
        prog[1]  = imm_instr(cpu_pkg::OP_ADD, 6'd2, 6'd0, random_imm() & 15'h007f);
        prog[2]  = reg_instr(cpu_pkg::OP_STORE, 6'd0, 6'd2, 6'd1);
        prog[3]  = imm_instr(4'b0001, 6'd1, 6'd2, random_imm());
        prog[4]  = reg_instr(4'b1100, 6'd2, 6'd1, 6'd1);
        prog[5]  = imm_instr(cpu_pkg::OP_NOP, 6'd1, 6'd2, random_imm());
        prog[6]  = reg_instr(4'b0010, 6'd1, 6'd2, 6'd2);
        prog[7]  = reg_instr(4'b0101, 6'd2, 6'd2, 6'd1);
        prog[8]  = reg_instr(4'b0111, 6'd1, 6'd2, 6'd1);
        prog[9]  = imm_instr(4'b1110, 6'd2, 6'd2, negative_imm());
        prog[10] = imm_instr(cpu_pkg::OP_ADD, 6'd3, 6'd1, 15'd0);
        prog[11] = imm_instr(cpu_pkg::OP_ADD, 6'd4, 6'd2, 15'd0);
        prog[12] = reg_instr(cpu_pkg::OP_LOAD, 6'd5, 6'd2, 6'd0);
        run_program(15);
        report_test();
    endtask

    initial begin
        reset      = 1'b1;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        pass_count = 0;
        fail_count = 0;

        reset_and_fetch();
        imm_and_reg_arith();
        logic_and_shift();
        store_then_load();
        non_writing_codes();

        $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+sim
design/cpu_pkg.sv
design/instr_fetch.sv
design/instr_decoder.sv
design/register_file.sv
design/alu.sv
design/mem_writeback.sv
design/mini_cpu.sv
sim/tb_mini_cpu.sv

// ==== Makefile ====
TOP = tb_mini_cpu

.PHONY: all lint sim clean

all: sim

# Static checks over the whole source list
lint:
	verilator --lint-only --timing -f sources.f --top-module $(TOP)

# Build and run; status follows the search for the pass line
sim:
	verilator --binary --timing -f sources.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^Simulation passed$$"

clean:
	rm -rf obj_dir
